// ==== ucpd_rx_pkg.sv ====
// --------------------------------------
// usb pd phy receive path definitions
// k-codes, 4b5b table, ordered-set
// templates, widths and shared types
// --------------------------------------
package ucpd_rx_pkg;

  // --------------------------------------
  // widths and counts
  localparam int SYMBOL_W   = 5;                      // one 4b5b line symbol
  localparam int NIBBLE_W   = 4;
  localparam int BYTE_W     = 8;
  localparam int KCODE_NUM  = 4;                      // k-codes per ordered set
  localparam int FIFO_DEPTH = 4;                      // symbol buffer entries
  localparam int BYTE_CNT_W = 10;                     // payload byte counter
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int ORDSET_NUM = 5;                      // ordered-set kinds checked

  typedef logic [SYMBOL_W-1:0]   symbol_t;
  typedef logic [NIBBLE_W-1:0]   nibble_t;
  typedef logic [BYTE_W-1:0]     byte_t;
  typedef logic [BYTE_CNT_W-1:0] byte_cnt_t;

  // --------------------------------------
  // k-codes, bit 0 is the first bit on the line
  localparam symbol_t KC_SYNC1 = 5'b11000;
  localparam symbol_t KC_SYNC2 = 5'b10001;
  localparam symbol_t KC_SYNC3 = 5'b00110;
  localparam symbol_t KC_RST1  = 5'b00111;
  localparam symbol_t KC_RST2  = 5'b11001;
  localparam symbol_t KC_EOP   = 5'b01101;

  // 4b5b data table, indexed by nibble value
  localparam symbol_t ENC_4B5B [2**NIBBLE_W] = '{
    5'b11110, 5'b01001, 5'b10100, 5'b10101,           // 0..3
    5'b01010, 5'b01011, 5'b01110, 5'b01111,           // 4..7
    5'b10010, 5'b10011, 5'b10110, 5'b10111,           // 8..b
    5'b11010, 5'b11011, 5'b11100, 5'b11101            // c..f
  };

  typedef enum logic [2:0] {
    OS_SOP       = 3'd0,
    OS_SOP1      = 3'd1,                              // sop'
    OS_SOP2      = 3'd2,                              // sop''
    OS_HARD_RST  = 3'd6,
    OS_CABLE_RST = 3'd5,
    OS_INVALID   = 3'd7
  } ordset_kind_e;

  // templates in priority order, first position received first
  localparam symbol_t OS_TPL [ORDSET_NUM][KCODE_NUM] = '{
    '{KC_SYNC1, KC_SYNC1, KC_SYNC1, KC_SYNC2},        // sop
    '{KC_SYNC1, KC_SYNC1, KC_SYNC3, KC_SYNC3},        // sop'
    '{KC_SYNC1, KC_SYNC3, KC_SYNC1, KC_SYNC3},        // sop''
    '{KC_RST1,  KC_RST1,  KC_RST1,  KC_RST2},         // hard reset
    '{KC_RST1,  KC_SYNC1, KC_RST1,  KC_SYNC3}         // cable reset
  };
  localparam ordset_kind_e OS_TPL_KIND [ORDSET_NUM] = '{
    OS_SOP, OS_SOP1, OS_SOP2, OS_HARD_RST, OS_CABLE_RST
  };

  typedef struct packed {
    logic         valid;                              // one-cycle event
    ordset_kind_e kind;
    logic [2:0]   bad_kcode;                          // 0 none, 1..4 position, 7 invalid
    logic         three_of_four;                      // matched with one k-code bad
  } rx_ordset_t;

  typedef struct packed {
    logic      valid;                                 // one-cycle event
    logic      eop_ok;                                // clean eop on a byte boundary
    logic      error;                                 // bad symbol or odd nibble count
    byte_cnt_t byte_cnt;                              // payload bytes in the frame
  } rx_frame_t;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_SOP  = 2'd1,
    ST_DATA = 2'd2
  } dec_state_e;

endpackage

// ==== ucpd_rx_symbol_shifter.sv ====
`timescale 1ns/1ps
// --------------------------------------
// receive symbol shifter
// packs recovered line bits into 5-bit
// symbols, flags a dropped symbol
// --------------------------------------
module ucpd_rx_symbol_shifter (
  input  logic                 ucpd_clk,
  input  logic                 ic_rst_n,
  input  logic                 line_bit,
  input  logic                 line_bit_valid,
  input  logic                 frame_start,
  output ucpd_rx_pkg::symbol_t sym_data,
  output logic                 sym_valid,
  input  logic                 sym_ready,
  output logic                 overflow
);
  import ucpd_rx_pkg::*;

  symbol_t                     shift_q;               // bits enter at the top
  logic [$clog2(SYMBOL_W)-1:0] bit_cnt;               // bits of the current symbol
  logic                        sym_done;              // fifth bit taken last edge
  logic                        slot_busy;             // previous symbol not yet taken

  assign slot_busy = sym_valid && !sym_ready;

  // --------------------------------------
  // bit counting, alignment from frame_start
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      bit_cnt  <= '0;
      sym_done <= 1'b0;
    end
    else if (frame_start)
    begin
      bit_cnt  <= '0;                                 // next bit starts a symbol
      sym_done <= 1'b0;
    end
    else
    begin
      sym_done <= 1'b0;
      if (line_bit_valid)
      begin
        if (bit_cnt == ($clog2(SYMBOL_W))'(SYMBOL_W - 1))
        begin
          bit_cnt  <= '0;
          sym_done <= 1'b1;                           // present on the next edge
        end
        else
          bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge ucpd_clk)
  begin
    if (line_bit_valid)
      shift_q <= {line_bit, shift_q[SYMBOL_W-1:1]};   // first bit ends at bit 0
  end

  // --------------------------------------
  // output slot and sticky overflow
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      sym_valid <= 1'b0;
      overflow  <= 1'b0;
    end
    else if (frame_start)
    begin
      sym_valid <= 1'b0;                              // stale symbol flushed
      overflow  <= 1'b0;
    end
    else if (sym_done && slot_busy)
      overflow <= 1'b1;                               // new symbol dropped
    else if (sym_done)
      sym_valid <= 1'b1;
    else if (sym_ready)
      sym_valid <= 1'b0;
  end

  always_ff @(posedge ucpd_clk)
  begin
    if (sym_done && !slot_busy)
      sym_data <= shift_q;
  end

  a_sym_hold: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    sym_valid && !sym_ready && !frame_start |=> sym_valid && $stable(sym_data));

endmodule

// ==== ucpd_rx_symbol_fifo.sv ====
`timescale 1ns/1ps
// --------------------------------------
// receive symbol buffer
// small first-word-fall-through fifo
// between shifter and frame decoder
// --------------------------------------
module ucpd_rx_symbol_fifo (
  input  logic                 ucpd_clk,
  input  logic                 ic_rst_n,
  input  logic                 frame_start,
  input  ucpd_rx_pkg::symbol_t wr_data,
  input  logic                 wr_valid,
  output logic                 wr_ready,
  output ucpd_rx_pkg::symbol_t rd_data,
  output logic                 rd_valid,
  input  logic                 rd_ready
);
  import ucpd_rx_pkg::*;

  symbol_t               mem [FIFO_DEPTH];            // symbol storage
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;                       // entries held
  logic                  push;
  logic                  pop;

  assign wr_ready = (count != FIFO_CNT_W'(FIFO_DEPTH)); // not full
  assign rd_valid = (count != '0);                      // not empty
  assign rd_data  = mem[rd_ptr];                        // head falls through
  assign push     = wr_valid && wr_ready;
  assign pop      = rd_valid && rd_ready;

  // --------------------------------------
  // pointers and fill count
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (frame_start)
    begin
      wr_ptr <= '0;                                   // new frame, drop leftovers
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;                      // wraps at depth
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge ucpd_clk)
  begin
    if (push)
      mem[wr_ptr] <= wr_data;                         // visible next cycle
  end

  // --------------------------------------
  // a write into a full or a read from an empty buffer breaks
  // the range of the count or its match with the pointer distance
  a_fill_track: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    (count <= FIFO_CNT_W'(FIFO_DEPTH)) &&
    (FIFO_PTR_W'(wr_ptr - rd_ptr) == FIFO_PTR_W'(count)));

endmodule

// ==== ucpd_rx_frame_decoder.sv ====
`timescale 1ns/1ps
// --------------------------------------
// receive frame decoder
// classifies the ordered set, decodes
// 4b5b payload to bytes, ends on eop
// --------------------------------------
module ucpd_rx_frame_decoder (
  input  logic                    ucpd_clk,
  input  logic                    ic_rst_n,
  input  logic                    frame_start,
  input  ucpd_rx_pkg::symbol_t    sym_data,
  input  logic                    sym_valid,
  output logic                    sym_ready,
  output ucpd_rx_pkg::byte_t      rx_byte,
  output logic                    byte_valid,
  input  logic                    byte_ready,
  output ucpd_rx_pkg::rx_ordset_t rx_ordset,
  output ucpd_rx_pkg::rx_frame_t  rx_frame
);
  import ucpd_rx_pkg::*;

  localparam int KC_IDX_W = $clog2(KCODE_NUM);

  dec_state_e            state;
  logic [KC_IDX_W-1:0]   kc_idx;                      // k-code position in the set
  symbol_t               kcode_q [KCODE_NUM-1];       // first three k-codes
  symbol_t               kc_set  [KCODE_NUM];         // full set incl. current symbol
  rx_ordset_t            os_next;                     // classification result
  logic                  sym_acc;                     // symbol handshake
  logic                  is_data;                     // symbol in 4b5b table
  nibble_t               dec_nib;
  nibble_t               low_nib;                     // first nibble of a pair
  logic                  nib_odd;                     // low nibble waiting
  logic                  eop_good;                    // eop on a byte boundary
  byte_cnt_t             byte_cnt;

  assign sym_acc  = sym_valid && sym_ready;
  assign eop_good = (sym_data == KC_EOP) && !nib_odd;

  always_comb
  begin
    case (state)
      ST_DATA: sym_ready = !byte_valid || byte_ready; // wait while a byte is held
      default: sym_ready = 1'b1;                      // sop collects, idle discards
    endcase
  end

  // --------------------------------------
  // 4b5b decode, table search
  always_comb
  begin
    is_data = 1'b0;
    dec_nib = '0;
    for (int i = 0; i < 2**NIBBLE_W; i++)
    begin
      if (sym_data == ENC_4B5B[i])
      begin
        is_data = 1'b1;
        dec_nib = NIBBLE_W'(i);
      end
    end
  end

  // --------------------------------------
  // ordered set, three of four rule
  always_comb
  begin
    for (int k = 0; k < KCODE_NUM - 1; k++)
      kc_set[k] = kcode_q[k];
    kc_set[KCODE_NUM-1] = sym_data;                   // fourth k-code arrives now
  end

  always_comb
  begin : classify
    logic       found;
    logic [2:0] match_cnt;
    logic [2:0] miss_pos;
    found                 = 1'b0;
    os_next.valid         = 1'b1;
    os_next.kind          = OS_INVALID;
    os_next.bad_kcode     = 3'd7;                     // no kind within one k-code
    os_next.three_of_four = 1'b0;
    for (int t = 0; t < ORDSET_NUM; t++)
    begin
      match_cnt = '0;
      miss_pos  = '0;
      for (int k = 0; k < KCODE_NUM; k++)
      begin
        if (kc_set[k] == OS_TPL[t][k])
          match_cnt = match_cnt + 1'b1;
        else
          miss_pos = 3'(k + 1);                       // 1-based position
      end
      if (!found && (match_cnt >= 3'd3))
      begin
        found                 = 1'b1;                 // first kind in order wins
        os_next.kind          = OS_TPL_KIND[t];
        os_next.bad_kcode     = miss_pos;             // 0 when all four agree
        os_next.three_of_four = (match_cnt != 3'd4);
      end
    end
  end

  // --------------------------------------
  // fsm, counters and event outputs
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      state      <= ST_IDLE;
      kc_idx     <= '0;
      nib_odd    <= 1'b0;
      byte_cnt   <= '0;
      byte_valid <= 1'b0;
      rx_ordset  <= '0;
      rx_frame   <= '0;
    end
    else if (frame_start)
    begin
      state           <= ST_SOP;                      // realigned, expect a set
      kc_idx          <= '0;
      nib_odd         <= 1'b0;
      byte_cnt        <= '0;
      byte_valid      <= 1'b0;                        // old frame byte discarded
      rx_ordset.valid <= 1'b0;
      rx_frame.valid  <= 1'b0;
    end
    else
    begin
      rx_ordset.valid <= 1'b0;
      rx_frame.valid  <= 1'b0;
      if (byte_valid && byte_ready)
        byte_valid <= 1'b0;
      case (state)
        ST_SOP:
          if (sym_acc)
          begin
            if (kc_idx == KC_IDX_W'(KCODE_NUM - 1))
            begin
              kc_idx    <= '0;
              rx_ordset <= os_next;
              if (os_next.kind inside {OS_SOP, OS_SOP1, OS_SOP2})
                state <= ST_DATA;                     // packet follows
              else
                state <= ST_IDLE;                     // resets and junk end here
            end
            else
              kc_idx <= kc_idx + 1'b1;
          end
        ST_DATA:
          if (sym_acc)
          begin
            if (is_data)
            begin
              nib_odd <= !nib_odd;
              if (nib_odd)
              begin
                byte_valid <= 1'b1;                   // high nibble completes byte
                byte_cnt   <= byte_cnt + 1'b1;
              end
            end
            else
            begin
              rx_frame.valid    <= 1'b1;
              rx_frame.eop_ok   <= eop_good;
              rx_frame.error    <= !eop_good;         // other k-code or odd nibbles
              rx_frame.byte_cnt <= byte_cnt;
              state             <= ST_IDLE;
            end
          end
        default: ;
      endcase
    end
  end

  always_ff @(posedge ucpd_clk)
  begin
    if (state == ST_SOP && sym_acc && kc_idx != KC_IDX_W'(KCODE_NUM - 1))
      kcode_q[kc_idx] <= sym_data;
    if (state == ST_DATA && sym_acc && is_data)
    begin
      if (nib_odd)
        rx_byte <= {dec_nib, low_nib};
      else
        low_nib <= dec_nib;                           // low nibble first
    end
  end

  a_byte_hold: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    byte_valid && !byte_ready && !frame_start |=> byte_valid && $stable(rx_byte));

endmodule

// ==== ucpd_rx_top.sv ====
`timescale 1ns/1ps
// --------------------------------------
// usb pd phy receive path top
// shifter, symbol fifo, frame decoder
// --------------------------------------
module ucpd_rx_top (
  input  logic                    ucpd_clk,
  input  logic                    ic_rst_n,
  input  logic                    line_bit,
  input  logic                    line_bit_valid,
  input  logic                    frame_start,
  input  logic                    byte_ready,
  output ucpd_rx_pkg::byte_t      rx_byte,
  output logic                    byte_valid,
  output ucpd_rx_pkg::rx_ordset_t rx_ordset,
  output ucpd_rx_pkg::rx_frame_t  rx_frame,
  output logic                    overflow
);
  import ucpd_rx_pkg::*;

  symbol_t sym_data;                                  // shifter to fifo
  logic    sym_valid;
  logic    sym_ready;
  symbol_t fifo_data;                                 // fifo to decoder
  logic    fifo_valid;
  logic    fifo_ready;

  ucpd_rx_symbol_shifter ucpd_rx_symbol_shifter_inst (
    .ucpd_clk       (ucpd_clk),
    .ic_rst_n       (ic_rst_n),
    .line_bit       (line_bit),
    .line_bit_valid (line_bit_valid),
    .frame_start    (frame_start),
    .sym_data       (sym_data),
    .sym_valid      (sym_valid),
    .sym_ready      (sym_ready),
    .overflow       (overflow)
  );

  ucpd_rx_symbol_fifo ucpd_rx_symbol_fifo_inst (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .frame_start (frame_start),
    .wr_data     (sym_data),
    .wr_valid    (sym_valid),
    .wr_ready    (sym_ready),
    .rd_data     (fifo_data),
    .rd_valid    (fifo_valid),
    .rd_ready    (fifo_ready)
  );

  ucpd_rx_frame_decoder ucpd_rx_frame_decoder_inst (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .frame_start (frame_start),
    .sym_data    (fifo_data),
    .sym_valid   (fifo_valid),
    .sym_ready   (fifo_ready),
    .rx_byte     (rx_byte),
    .byte_valid  (byte_valid),
    .byte_ready  (byte_ready),
    .rx_ordset   (rx_ordset),
    .rx_frame    (rx_frame)
  );

endmodule

// ==== tb_ucpd_rx_model.svh ====
// ----------------------------------------
// reference model for the receive path
// 4b5b encoding, ordered-set rule and
// expected result queues
// ----------------------------------------
`ifndef TB_UCPD_RX_MODEL_SVH
`define TB_UCPD_RX_MODEL_SVH

// two line symbols for one byte, low nibble in bits 4:0 goes out first
function automatic logic [2*SYMBOL_W-1:0] encode_byte(input byte_t b);
  return {ENC_4B5B[b[7:4]], ENC_4B5B[b[3:0]]};
endfunction

// k-code expected at one position of an ordered set
function automatic symbol_t kcode_template(input int tpl, input int pos);
  case (tpl)
    0: return (pos == 3) ? KC_SYNC2 : KC_SYNC1;       // sop
    1: return (pos < 2) ? KC_SYNC1 : KC_SYNC3;        // sop'
    2: return (pos % 2 == 0) ? KC_SYNC1 : KC_SYNC3;   // sop''
    3: return (pos == 3) ? KC_RST2 : KC_RST1;         // hard reset
    default:
    begin
      if (pos % 2 == 0)
        return KC_RST1;                               // cable reset
      return (pos == 1) ? KC_SYNC1 : KC_SYNC3;
    end
  endcase
endfunction

function automatic ordset_kind_e kind_of(input int tpl);
  case (tpl)
    0:       return OS_SOP;
    1:       return OS_SOP1;
    2:       return OS_SOP2;
    3:       return OS_HARD_RST;
    default: return OS_CABLE_RST;
  endcase
endfunction

// three of four positions must agree, earlier kind wins
function automatic rx_ordset_t classify_ordset(input symbol_t kc [KCODE_NUM]);
  rx_ordset_t os;
  logic       found;
  int         hits;
  int         miss;
  found            = 1'b0;
  os.valid         = 1'b1;
  os.kind          = OS_INVALID;
  os.bad_kcode     = 3'd7;                          // reported when nothing matches
  os.three_of_four = 1'b0;
  for (int t = 0; t < ORDSET_NUM; t++)
  begin
    hits = 0;
    miss = 0;
    for (int k = 0; k < KCODE_NUM; k++)
    begin
      if (kc[k] == kcode_template(t, k))
        hits++;
      else
        miss = k + 1;                               // positions count from 1
    end
    if (!found && hits >= 3)
    begin
      found            = 1'b1;
      os.kind          = kind_of(t);
      os.bad_kcode     = 3'(miss);
      os.three_of_four = (hits == 3);
    end
  end
  return os;
endfunction

// push what the dut should report for the frame now in payload
function automatic void queue_expected(input symbol_t kc [KCODE_NUM], input int err_at,
                                       input logic stalled);
  rx_ordset_t os;
  rx_frame_t  fr;
  int         n_good;
  os = classify_ordset(kc);
  exp_ordsets.push_back(os);
  if (!stalled && (os.kind inside {OS_SOP, OS_SOP1, OS_SOP2}))
  begin
    n_good = (err_at < 0) ? payload.size() : err_at; // bytes before the bad symbol
    for (int i = 0; i < n_good; i++)
      exp_bytes.push_back(payload[i]);
    fr.valid    = 1'b1;
    fr.eop_ok   = (err_at < 0);
    fr.error    = (err_at >= 0);
    fr.byte_cnt = byte_cnt_t'(n_good);
    exp_frames.push_back(fr);
  end
endfunction

`endif

// ==== tb_ucpd_rx.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// testbench for the usb pd receive path
// serial symbol stimulus, reference queues
// and a compare process on the clock edge
// ----------------------------------------
module tb_ucpd_rx;
  import ucpd_rx_pkg::*;

  localparam int CLK_HALF       = 50;               // 100 ns period
  localparam int RST_CYCLES     = 16;
  localparam int IDLE_GAP       = 20;               // quiet cycles after each frame
  localparam int RAND_BYTES_MAX = 16;
  localparam int LONG_BYTES     = 24;
  localparam int ERR_BYTES      = 8;
  localparam int STALL_BYTES    = 30;
  localparam int READY_HIGH     = 0;
  localparam int READY_GAPS     = 1;
  localparam int READY_LOW      = 2;
  // every frame sent below, k-codes + payload symbols + terminators
  localparam int TOTAL_SYMS     = 3 * ORDSET_NUM * (KCODE_NUM + 1)
                                + 3 * (KCODE_NUM + 2 * RAND_BYTES_MAX + 1)
                                + 2 * (KCODE_NUM + 2 * LONG_BYTES + 1)
                                + (KCODE_NUM + 2 * ERR_BYTES + 2)
                                + (KCODE_NUM + 2 * STALL_BYTES + 1)
                                + (KCODE_NUM + 2 * ERR_BYTES + 1);
  localparam int TIMEOUT_CYCLES = TOTAL_SYMS * SYMBOL_W * 2 * 3 + 500;

  logic       ucpd_clk;
  logic       ic_rst_n;
  logic       line_bit;
  logic       line_bit_valid;
  logic       frame_start;
  logic       byte_ready;
  byte_t      rx_byte;
  logic       byte_valid;
  rx_ordset_t rx_ordset;
  rx_frame_t  rx_frame;
  logic       overflow;

  integer     seed = 32'h73c2;
  int         cycle_cnt = 0;
  int         ready_mode;                           // byte_ready pattern
  symbol_t    tx_syms [$];                          // symbols of the next frame
  byte_t      payload [$];
  byte_t      exp_bytes [$];
  rx_ordset_t exp_ordsets [$];
  rx_frame_t  exp_frames [$];

  `include "tb_ucpd_rx_model.svh"

  ucpd_rx_top ucpd_rx_top_inst (
    .ucpd_clk       (ucpd_clk),
    .ic_rst_n       (ic_rst_n),
    .line_bit       (line_bit),
    .line_bit_valid (line_bit_valid),
    .frame_start    (frame_start),
    .byte_ready     (byte_ready),
    .rx_byte        (rx_byte),
    .byte_valid     (byte_valid),
    .rx_ordset      (rx_ordset),
    .rx_frame       (rx_frame),
    .overflow       (overflow)
  );

  always #(CLK_HALF) ucpd_clk = ~ucpd_clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  // ----------------------------------------
  // stimulus helpers, all on the falling edge
  task automatic tick();
    @(negedge ucpd_clk);
    case (ready_mode)
      READY_GAPS: byte_ready = (($random(seed) & 3) != 0); // about one gap in four
      READY_LOW:  byte_ready = 1'b0;
      default:    byte_ready = 1'b1;
    endcase
  endtask

  task automatic check_overflow(input logic exp);
    assert (overflow == exp)
      else report_failure($sformatf("error: overflow got %h expected %h", overflow, exp));
  endtask

  task automatic load_frame(input int tpl, input int bad_a, input int bad_b,
                            input int n_bytes, input int err_at, input logic stalled);
    symbol_t                 kc [KCODE_NUM];
    nibble_t                 nib;
    byte_t                   b;
    logic [2*SYMBOL_W-1:0]   pair;
    tx_syms.delete();
    payload.delete();
    for (int k = 0; k < KCODE_NUM; k++)
    begin
      kc[k] = kcode_template(tpl, k);
      if (k + 1 == bad_a || k + 1 == bad_b)
      begin
        nib   = nibble_t'($random(seed));
        kc[k] = ENC_4B5B[nib];                      // data symbol, never a k-code
      end
      tx_syms.push_back(kc[k]);
    end
    for (int i = 0; i < n_bytes; i++)
    begin
      b = byte_t'($random(seed));
      payload.push_back(b);
      if (i == err_at)
        tx_syms.push_back(KC_RST1);                 // k-code inside the payload
      pair = encode_byte(b);
      tx_syms.push_back(pair[SYMBOL_W-1:0]);
      tx_syms.push_back(pair[2*SYMBOL_W-1:SYMBOL_W]);
    end
    tx_syms.push_back(KC_EOP);
    queue_expected(kc, err_at, stalled);
  endtask

  task automatic send_frame(input int mode);
    symbol_t sym;
    tick();
    frame_start = 1'b1;                             // realign all three blocks
    tick();
    frame_start = 1'b0;
    ready_mode  = mode;
    check_overflow(1'b0);                           // cleared by frame_start
    foreach (tx_syms[i])
    begin
      sym = tx_syms[i];
      repeat (SYMBOL_W)
      begin
        tick();
        line_bit       = sym[0];                    // bit 0 goes out first
        line_bit_valid = 1'b1;
        sym            = sym >> 1;
        tick();
        line_bit_valid = 1'b0;
      end
    end
    while (exp_bytes.size() + exp_ordsets.size() + exp_frames.size() != 0)
      tick();
    repeat (IDLE_GAP)
      tick();                                       // room for stray events
    check_overflow(mode == READY_LOW);
  endtask

  // ----------------------------------------
  // compare process, samples before the edge updates
  always @(posedge ucpd_clk)
  begin : compare
    byte_t      exp_byte;
    rx_ordset_t exp_os;
    rx_frame_t  exp_fr;
    if (ic_rst_n)
    begin
      if (byte_valid && byte_ready)
      begin
        assert (exp_bytes.size() != 0)
          else report_failure("a byte was delivered that no frame should produce");
        assert (exp_ordsets.size() == 0)
          else report_failure("a byte was delivered before its ordered set was reported");
        exp_byte = exp_bytes.pop_front();
        assert (rx_byte == exp_byte)
          else report_failure($sformatf("error: rx_byte got %h expected %h",
                                        rx_byte, exp_byte));
      end
      if (rx_ordset.valid)
      begin
        assert (exp_ordsets.size() != 0)
          else report_failure("an ordered set was reported that was never sent");
        exp_os = exp_ordsets.pop_front();
        assert (rx_ordset == exp_os)
          else report_failure($sformatf("error: rx_ordset got %h expected %h",
                                        rx_ordset, exp_os));
      end
      if (rx_frame.valid)
      begin
        assert (exp_frames.size() != 0)
          else report_failure("a frame end was reported where none was due");
        assert (exp_bytes.size() == 0 && exp_ordsets.size() == 0)
          else report_failure("the frame end came before all of its bytes were delivered");
        exp_fr = exp_frames.pop_front();
        assert (rx_frame == exp_fr)
          else report_failure($sformatf("error: rx_frame got %h expected %h",
                                        rx_frame, exp_fr));
      end
    end
  end

  always @(posedge ucpd_clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      report_failure("timeout, the receive path stopped making progress");
  end

  // ----------------------------------------
  // test sequence
  initial
  begin : stimulus
    int a;
    int b;
    int off;
    ucpd_clk       = 1'b0;
    ic_rst_n       = 1'b0;
    line_bit       = 1'b0;
    line_bit_valid = 1'b0;
    frame_start    = 1'b0;
    byte_ready     = 1'b1;
    ready_mode     = READY_HIGH;
    repeat (RST_CYCLES)
      @(negedge ucpd_clk);
    ic_rst_n = 1'b1;
    tick();
    assert ({byte_valid, rx_ordset.valid, rx_frame.valid, overflow} == 4'b0)
      else report_failure($sformatf("error: valid and overflow flags got %h expected 0",
                                    {byte_valid, rx_ordset.valid, rx_frame.valid, overflow}));

    for (int t = 0; t < ORDSET_NUM; t++)
    begin
      load_frame(t, 0, 0, 0, -1, 1'b0);             // clean set, empty payload
      send_frame(READY_HIGH);
    end
    for (int t = 0; t < ORDSET_NUM; t++)
    begin
      a = 1 + ($random(seed) & 3);
      load_frame(t, a, 0, 0, -1, 1'b0);             // one bad k-code
      send_frame(READY_HIGH);
    end
    for (int t = 0; t < ORDSET_NUM; t++)
    begin
      a   = 1 + ($random(seed) & 3);
      off = 1 + (($random(seed) & 255) % 3);
      b   = 1 + ((a - 1 + off) % KCODE_NUM);        // second, different position
      load_frame(t, a, b, 0, -1, 1'b0);
      send_frame(READY_HIGH);
    end

    repeat (3)
    begin
      load_frame(($random(seed) & 255) % 3, 0, 0, 1 + ($random(seed) & 15), -1, 1'b0);
      send_frame(READY_HIGH);
    end
    repeat (2)
    begin
      load_frame(0, 0, 0, LONG_BYTES, -1, 1'b0);
      send_frame(READY_GAPS);                       // random back-pressure
    end

    load_frame(0, 0, 0, ERR_BYTES, $random(seed) & 7, 1'b0);
    send_frame(READY_HIGH);

    load_frame(0, 0, 0, STALL_BYTES, -1, 1'b1);     // output stalled, buffer overruns
    send_frame(READY_LOW);
    load_frame(1, 0, 0, ERR_BYTES, -1, 1'b0);
    send_frame(READY_HIGH);

    if (exp_bytes.size() + exp_ordsets.size() + exp_frames.size() == 0)
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
    else
      report_failure("expected results were left over at the end of the run");
  end

endmodule

// ==== filelist.f ====
+incdir+.
ucpd_rx_pkg.sv
ucpd_rx_symbol_shifter.sv
ucpd_rx_symbol_fifo.sv
ucpd_rx_frame_decoder.sv
ucpd_rx_top.sv
tb_ucpd_rx.sv

// ==== Makefile ====
# Verilator flow for the USB PD receive path

VERILATOR  ?= verilator
TOP        ?= tb_ucpd_rx
RTL_TOP    ?= ucpd_rx_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= ucpd_rx_pkg.sv ucpd_rx_symbol_shifter.sv ucpd_rx_symbol_fifo.sv \
              ucpd_rx_frame_decoder.sv ucpd_rx_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# exit status of the simulation binary is the test result
run: build
	$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
